//--- common/bch_pkg.sv
package bch_pkg;

    typedef logic [7:0] gf_elem_t; // GF(2^6) keeps bits 7:6 at zero

    typedef enum logic {
        CODE_63_51   = 1'b0, // GF(2^6), x^6+x+1
        CODE_255_239 = 1'b1  // GF(2^8), x^8+x^4+x^3+x^2+1
    } code_e;

    typedef enum logic {
        IDLE  = 1'b0,
        ACCUM = 1'b1
    } ctrl_state_e;

    typedef struct packed {
        logic [7:0] data;
        logic       sof;  // first beat of a codeword
        code_e      code;
    } beat_t;

    typedef struct packed {
        gf_elem_t s1;
        gf_elem_t s2;
        gf_elem_t s3;
        gf_elem_t s4;
        code_e    code;
    } syndrome_t;

    localparam logic [5:0] BEATS_63  = 6'd8;
    localparam logic [5:0] BEATS_255 = 6'd32;

    // field polynomials without the leading term
    localparam gf_elem_t POLY_63  = 8'h03;
    localparam gf_elem_t POLY_255 = 8'h1d;

    function automatic logic [5:0] beats_per_code(code_e code);
        return (code == CODE_63_51) ? BEATS_63 : BEATS_255;
    endfunction

    // multiply by alpha, one step of the LFSR
    function automatic gf_elem_t gf_xtime(gf_elem_t a, code_e code);
        gf_elem_t r;
        if (code == CODE_63_51) begin
            r = {2'b00, a[4:0], 1'b0} ^ (a[5] ? POLY_63 : 8'h00);
        end else begin
            r = {a[6:0], 1'b0} ^ (a[7] ? POLY_255 : 8'h00);
        end
        return r;
    endfunction

    function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b, code_e code);
        gf_elem_t p;
        p = '0;
        for (int i = 7; i >= 0; i--) begin // msb first, shift then add
            p = gf_xtime(p, code);
            if (b[i]) begin
                p = p ^ a;
            end
        end
        return p;
    endfunction

    // alpha^e, exponent reduced by the group order
    function automatic gf_elem_t gf_pow(int unsigned e, code_e code);
        int unsigned n;
        gf_elem_t    r;
        n = (code == CODE_63_51) ? (e % 63) : (e % 255);
        r = 8'h01;
        for (int unsigned i = 0; i < 254; i++) begin // fixed bound
            if (i < n) begin
                r = gf_xtime(r, code);
            end
        end
        return r;
    endfunction

endpackage

//--- compile.f
+incdir+tb
common/bch_pkg.sv
rtl/beat_fifo.sv
syndrome/syndrome_ctrl.sv
syndrome/odd_syndrome_acc.sv
syndrome/syndrome_result.sv
rtl/bch_syndrome_top.sv
tb/tb_bch_syndrome.sv

//--- rtl/bch_syndrome_top.sv
module bch_syndrome_top import bch_pkg::*; #(
    parameter int DEPTH       = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_beat_valid,
    input  beat_t     i_beat,
    output logic      o_in_credit,
    input  logic      i_res_credit,
    output logic      o_res_valid,
    output syndrome_t o_res
);
    beat_t      head;
    logic       empty;
    logic       pop;
    logic       step;
    logic       restart;
    logic       last;
    code_e      code;
    logic [7:0] data;
    gf_elem_t   s1;
    gf_elem_t   s3;

    beat_fifo #(
        .DEPTH(DEPTH)
    ) u_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (i_beat_valid),
        .i_push_beat (i_beat),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (empty),
        .o_in_credit (o_in_credit)
    );

    syndrome_ctrl #(
        .RES_CREDITS(RES_CREDITS)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head       (head),
        .i_empty      (empty),
        .i_res_credit (i_res_credit),
        .o_pop        (pop),
        .o_step       (step),
        .o_restart    (restart),
        .o_code       (code),
        .o_data       (data),
        .o_last       (last)
    );

    odd_syndrome_acc #(.J(1)) u_acc_s1 (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(step), .i_restart(restart),
        .i_code(code), .i_data(data), .o_syn(s1)
    );

    odd_syndrome_acc #(.J(3)) u_acc_s3 (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(step), .i_restart(restart),
        .i_code(code), .i_data(data), .o_syn(s3)
    );

    syndrome_result u_result (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_last      (last),
        .i_code      (code),
        .i_s1        (s1),
        .i_s3        (s3),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

//--- rtl/beat_fifo.sv
module beat_fifo import bch_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_push,
    input  beat_t i_push_beat,
    input  logic  i_pop,
    output beat_t o_head,
    output logic  o_empty,
    output logic  o_in_credit
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    beat_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          credit_q;

    // sender holds credits, so a push never finds the buffer full
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_beat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CW'(i_push) - CW'(i_pop);
            credit_q <= i_pop; // one credit back per consumed beat
        end
    end

    assign o_head      = mem[rd_ptr];
    assign o_empty     = (count == '0);
    assign o_in_credit = credit_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_bch_syndrome -f compile.f -o sim_bch &&
./obj_dir/sim_bch | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- syndrome/odd_syndrome_acc.sv
module odd_syndrome_acc import bch_pkg::*; #(
    parameter int J = 1
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_step,
    input  logic       i_restart,
    input  code_e      i_code,
    input  logic [7:0] i_data,
    output gf_elem_t   o_syn
);
    // one beat moves every bit up by 8 degrees
    localparam gf_elem_t BEAT_63  = gf_pow(8 * J, CODE_63_51);
    localparam gf_elem_t BEAT_255 = gf_pow(8 * J, CODE_255_239);

    gf_elem_t bit_term [8];
    gf_elem_t beat_mul;
    gf_elem_t bit_sum;
    gf_elem_t syn_q;
    gf_elem_t syn_nxt;

    genvar k;
    generate
        for (k = 0; k < 8; k++) begin : g_bit
            localparam gf_elem_t POW_63  = gf_pow(J * k, CODE_63_51);   // alpha^(J*k)
            localparam gf_elem_t POW_255 = gf_pow(J * k, CODE_255_239);

            assign bit_term[k] = !i_data[k] ? '0 :
                                 (i_code == CODE_63_51) ? POW_63 : POW_255;
        end
    endgenerate

    always_comb begin
        bit_sum = '0;
        for (int n = 0; n < 8; n++) begin
            bit_sum = bit_sum ^ bit_term[n];
        end
    end

    assign beat_mul = (i_code == CODE_63_51) ? BEAT_63 : BEAT_255;

    // Horner step, old value ignored on the sof beat
    assign syn_nxt = (i_restart ? '0 : gf_mul(syn_q, beat_mul, i_code)) ^ bit_sum;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            syn_q <= '0;
        end else if (i_step) begin
            syn_q <= syn_nxt;
        end
    end

    assign o_syn = syn_q;

endmodule

//--- syndrome/syndrome_ctrl.sv
module syndrome_ctrl import bch_pkg::*; #(
    parameter int RES_CREDITS = 2
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  beat_t      i_head,
    input  logic       i_empty,
    input  logic       i_res_credit,
    output logic       o_pop,
    output logic       o_step,
    output logic       o_restart,
    output code_e      o_code,
    output logic [7:0] o_data,
    output logic       o_last
);
    localparam int CW = $clog2(RES_CREDITS + 1);

    ctrl_state_e   state;
    logic [5:0]    cnt;      // beats taken of the current codeword
    code_e         code_q;
    logic [CW-1:0] credits;
    logic          has_beat;
    logic          is_sof;
    logic          at_last;
    logic          accum_pop;

    assign has_beat = !i_empty;
    assign is_sof   = has_beat && i_head.sof; // restarts even mid codeword
    assign at_last  = (cnt == beats_per_code(code_q) - 6'd1);

    // last beat waits here while no result slot is free
    assign accum_pop = has_beat && !i_head.sof && (state == ACCUM) &&
                       (!at_last || (credits != '0));

    assign o_step    = is_sof || accum_pop;
    assign o_pop     = o_step || (has_beat && !i_head.sof && (state == IDLE)); // stray beat dropped
    assign o_restart = is_sof;
    assign o_last    = accum_pop && at_last;
    assign o_code    = is_sof ? i_head.code : code_q;
    assign o_data    = i_head.data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state   <= IDLE;
            cnt     <= '0;
            code_q  <= CODE_63_51;
            credits <= CW'(RES_CREDITS);
        end else begin
            if (is_sof) begin
                state  <= ACCUM;
                cnt    <= 6'd1;
                code_q <= i_head.code;
            end else if (o_last) begin
                state <= IDLE;
                cnt   <= '0;
            end else if (accum_pop) begin
                cnt <= cnt + 6'd1;
            end
            credits <= credits + CW'(i_res_credit) - CW'(o_last); // reserve on last pop
        end
    end

endmodule

//--- syndrome/syndrome_result.sv
module syndrome_result import bch_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_last,
    input  code_e     i_code,
    input  gf_elem_t  i_s1,
    input  gf_elem_t  i_s3,
    output logic      o_res_valid,
    output syndrome_t o_res
);
    logic      last_q;      // accumulators hold final values this cycle
    code_e     code_q;
    gf_elem_t  s2;
    gf_elem_t  s4;
    syndrome_t res_q;
    logic      res_valid_q;

    // even syndromes of a binary code are squares
    assign s2 = gf_mul(i_s1, i_s1, code_q);
    assign s4 = gf_mul(s2, s2, code_q);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            last_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            last_q      <= i_last;
            res_valid_q <= last_q; // single cycle pulse
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_last) begin
            code_q <= i_code;
        end
        if (last_q) begin
            // next codeword may already be stepping the accumulators
            res_q.s1   <= i_s1;
            res_q.s2   <= s2;
            res_q.s3   <= i_s3;
            res_q.s4   <= s4;
            res_q.code <= code_q;
        end
    end

    assign o_res_valid = res_valid_q;
    assign o_res       = res_q;

endmodule

//--- tb/tb_bch_model.svh
`ifndef TB_BCH_MODEL_SVH
`define TB_BCH_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [7:0] rand_byte();
    rng_state = xorshift(rng_state);
    return rng_state[7:0];
endfunction

// direct sum of alpha^(j*degree) over every set bit of the codeword
function automatic syndrome_t model_syndrome(input code_e c);
    syndrome_t r;
    int        nb;
    int        d;
    nb = (c == CODE_63_51) ? 8 : 32;
    r = '0;
    r.code = c;
    for (int b = 0; b < nb; b++) begin
        for (int k = 0; k < 8; k++) begin
            if (word[b][k]) begin
                d = 8 * (nb - 1 - b) + k; // first beat carries the highest degrees
                r.s1 = r.s1 ^ gf_pow(d, c);
                r.s2 = r.s2 ^ gf_pow(2 * d, c);
                r.s3 = r.s3 ^ gf_pow(3 * d, c);
                r.s4 = r.s4 ^ gf_pow(4 * d, c);
            end
        end
    end
    return r;
endfunction

task automatic compare_syndrome(input string name, input syndrome_t got, input syndrome_t exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic compare_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        errors++;
    end
endtask

`endif

//--- tb/tb_bch_syndrome.sv
module tb_bch_syndrome import bch_pkg::*; ();
    localparam int DEPTH       = 4;
    localparam int RES_CREDITS = 2;
    localparam int WAIT_LIMIT  = 2000; // cycles per wait

    logic      i_clk = 1'b0;
    logic      i_rst_n;
    logic      i_beat_valid;
    beat_t     i_beat;
    logic      o_in_credit;
    logic      i_res_credit = 1'b0;
    logic      o_res_valid;
    syndrome_t o_res;

    logic [7:0]  word [32];        // codeword being sent, beat 0 first
    logic [31:0] rng_state = 32'hd7cfdfc4;
    syndrome_t   got_q [$];
    syndrome_t   exp_q [$];
    int          rd_idx = 0;
    int          returned = 0;     // result credits handed back
    int          beats_sent = 0;
    int          credit_pulses = 0;
    int          errors = 0;
    int          checks = 0;
    bit          auto_credit = 1'b1;

    `include "tb_bch_model.svh"

    bch_syndrome_top #(.DEPTH(DEPTH), .RES_CREDITS(RES_CREDITS)) i_dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_beat_valid(i_beat_valid), .i_beat(i_beat),
        .o_in_credit(o_in_credit), .i_res_credit(i_res_credit),
        .o_res_valid(o_res_valid), .o_res(o_res)
    );

    always #50 i_clk = ~i_clk;

    always @(negedge i_clk) begin // outputs settled mid cycle
        if (o_in_credit === 1'b1) credit_pulses++;
        if (o_res_valid === 1'b1) got_q.push_back(o_res);
    end

    always @(posedge i_clk) begin
        #5;
        if (auto_credit && returned < got_q.size()) begin
            i_res_credit = 1'b1;
            returned++;
        end else begin
            i_res_credit = 1'b0;
        end
    end

    task automatic send_beat(input logic [7:0] d, input logic sof, input code_e c);
        int t;
        t = 0;
        @(posedge i_clk);
        #5;
        i_beat_valid = 1'b0;
        while (DEPTH - beats_sent + credit_pulses <= 0 && t < WAIT_LIMIT) begin
            @(posedge i_clk);
            #5;
            t++;
        end
        if (DEPTH - beats_sent + credit_pulses <= 0) begin
            $display("timeout at %0t: no input credit came back", $time);
            errors++;
        end else begin
            i_beat_valid = 1'b1;
            i_beat = '{data: d, sof: sof, code: c};
            beats_sent++;
        end
    endtask

    task automatic idle();
        @(posedge i_clk);
        #5;
        i_beat_valid = 1'b0;
    endtask

    task automatic fill_random(input code_e c);
        for (int b = 0; b < 32; b++) word[b] = rand_byte();
        if (c == CODE_63_51) word[0][7] = 1'b0; // padding bit
    endtask

    task automatic send_word(input code_e c);
        int nb;
        nb = (c == CODE_63_51) ? 8 : 32;
        for (int b = 0; b < nb; b++) send_beat(word[b], b == 0, c);
        exp_q.push_back(model_syndrome(c));
    endtask

    task automatic wait_results(input int n);
        int t;
        t = 0;
        while (got_q.size() < rd_idx + n && t < WAIT_LIMIT) begin
            @(posedge i_clk);
            t++;
        end
        if (got_q.size() < rd_idx + n) begin
            $display("timeout at %0t: expected %0d results, saw %0d", $time, n,
                     got_q.size() - rd_idx);
            errors++;
        end
    endtask

    task automatic check_results();
        while (exp_q.size() > 0 && rd_idx < got_q.size()) begin
            compare_syndrome("o_res", got_q[rd_idx], exp_q.pop_front());
            rd_idx++;
        end
        compare_count("missing results", exp_q.size(), 0);
        compare_count("extra results", got_q.size() - rd_idx, 0);
        exp_q.delete();
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%s: %0d errors", name, errors - err0);
    endtask

    task automatic test_zero_words();
        int err0;
        err0 = errors;
        for (int b = 0; b < 32; b++) word[b] = 8'h00;
        send_word(CODE_63_51);
        send_word(CODE_255_239);
        idle();
        wait_results(2);
        check_results();
        report_test("zero codewords", err0);
    endtask

    task automatic test_single_bit();
        int        err0;
        int        pos [5];
        syndrome_t exp;
        err0 = errors;
        pos = '{0, 1, 9, 30, 62};
        foreach (pos[i]) begin
            for (int b = 0; b < 32; b++) word[b] = 8'h00;
            word[7 - pos[i] / 8][pos[i] % 8] = 1'b1;
            for (int b = 0; b < 8; b++) send_beat(word[b], b == 0, CODE_63_51);
            exp = '0;
            exp.s1 = gf_pow(pos[i], CODE_63_51);
            exp.s2 = gf_pow(2 * pos[i], CODE_63_51);
            exp.s3 = gf_pow(3 * pos[i], CODE_63_51);
            exp.s4 = gf_pow(4 * pos[i], CODE_63_51);
            exp.code = CODE_63_51;
            exp_q.push_back(exp);
        end
        idle();
        wait_results(5);
        check_results();
        report_test("single bit", err0);
    endtask

    task automatic test_random_stream();
        int    err0;
        code_e c;
        err0 = errors;
        for (int i = 0; i < 5; i++) begin
            c = (i % 2 == 0) ? CODE_63_51 : CODE_255_239;
            fill_random(c);
            send_word(c);
        end
        idle();
        wait_results(5);
        check_results();
        report_test("random stream", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int t;
        err0 = errors;
        t = 0;
        while (returned < got_q.size() && t < WAIT_LIMIT) begin // earlier credits first
            @(posedge i_clk);
            t++;
        end
        if (returned < got_q.size()) begin
            $display("timeout at %0t: earlier result credits were not returned", $time);
            errors++;
        end
        auto_credit = 1'b0;
        for (int i = 0; i < 3; i++) begin
            fill_random(CODE_63_51);
            send_word(CODE_63_51);
        end
        idle();
        wait_results(2);
        repeat (40) @(posedge i_clk);
        compare_count("results while credits held", got_q.size() - rd_idx, 2);
        auto_credit = 1'b1; // third result needs a freed slot
        wait_results(3);
        check_results();
        report_test("result back-pressure", err0);
    endtask

    task automatic test_framing();
        int err0;
        int n0;
        err0 = errors;
        n0 = got_q.size();
        for (int b = 0; b < 8; b++) send_beat(8'h5a, 1'b0, CODE_63_51); // a codeword's worth
        idle();
        repeat (20) @(posedge i_clk);
        compare_count("results after stray beat", got_q.size() - n0, 0);
        fill_random(CODE_255_239);
        for (int b = 0; b < 3; b++) send_beat(word[b], b == 0, CODE_255_239);
        fill_random(CODE_63_51);
        send_word(CODE_63_51); // restarts the partial codeword
        idle();
        wait_results(1);
        check_results();
        report_test("framing", err0);
    endtask

    task automatic test_input_credits();
        int err0;
        int t;
        err0 = errors;
        t = 0;
        while (credit_pulses < beats_sent && t < WAIT_LIMIT) begin
            @(posedge i_clk);
            t++;
        end
        compare_count("o_in_credit pulses", credit_pulses, beats_sent);
        compare_count("sender credits", DEPTH - beats_sent + credit_pulses, DEPTH);
        report_test("input credits", err0);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_beat_valid = 1'b0;
        i_beat = '0;
        repeat (8) @(posedge i_clk);
        #5;
        i_rst_n = 1'b1;
        test_zero_words();
        test_single_bit();
        test_random_stream();
        test_backpressure();
        test_framing();
        test_input_credits();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
